// File: symmDecorr_params.svh
`ifndef SYMMDECORR_PARAMS_SVH
`define SYMMDECORR_PARAMS_SVH

// Q13 fixed-point format of the matrix elements

`define ELEM_W 26     // Signed element width

`define FRAC_BITS 13  // Products shift right by this before summing

// Intermediate dot product sums, wide enough for a full product
`define ACC_W 52

// Square matrix, streamed row-major
`define MAT_DIM 4

`endif

// File: symmDecorrPkg.sv
`default_nettype none

`include "symmDecorr_params.svh"

package symmDecorrPkg;

    // One signed Q13 matrix element
    typedef logic signed [`ELEM_W-1:0] elem_t;

    // c0 sits in the top bits
    typedef struct packed {
        elem_t c0;
        elem_t c1;
        elem_t c2;
        elem_t c3;
    } row_t;

    // Row-major, r0 in the top bits
    typedef struct packed {
        row_t r0;
        row_t r1;
        row_t r2;
        row_t r3;
    } matrix_t;

endpackage

`default_nettype wire

// File: matrixLoader.sv
`default_nettype none

`include "symmDecorr_params.svh"

module matrixLoader (
    input  wire logic                   clk_mul3,
    input  wire logic                   rst,
    input  wire logic                   elemValid,
    input  wire symmDecorrPkg::elem_t   elemData,
    output symmDecorrPkg::matrix_t      matrixW,
    output logic                        matReady
);

    localparam int NumElems = `MAT_DIM * `MAT_DIM;
    localparam int FlatW    = NumElems * `ELEM_W;

    logic [3:0]       elemCnt;
    logic [FlatW-1:0] stage;
    logic             lastElem;

    assign lastElem = elemValid && (elemCnt == 4'(NumElems - 1));

    always_ff @(posedge clk_mul3) begin
        if (rst) begin
            elemCnt  <= '0;
            matReady <= 1'b0;
        end else begin
            matReady <= lastElem;  // One cycle after the 16th element
            if (elemValid) begin
                elemCnt <= elemCnt + 4'd1;  // Wraps after element 15
            end
        end
    end

    // Element 0 goes to the top slice so the flat vector matches matrix_t
    always_ff @(posedge clk_mul3) begin
        if (elemValid) begin
            stage[(NumElems - 1 - elemCnt) * `ELEM_W +: `ELEM_W] <= elemData;
        end
    end

    // Only a complete matrix is published
    always_ff @(posedge clk_mul3) begin
        if (lastElem) begin
            matrixW <= symmDecorrPkg::matrix_t'({stage[FlatW-1:`ELEM_W], elemData});
        end
    end

endmodule

`default_nettype wire

// File: symmMulRow.sv
`default_nettype none

`include "symmDecorr_params.svh"

module symmMulRow #(
    parameter int ROW_IDX = 0
) (
    input  wire logic                   clk_mul3,
    input  wire logic                   rst,
    input  wire logic                   matReady,
    input  wire logic                   mulEn,
    input  wire symmDecorrPkg::matrix_t matrixW,
    output symmDecorrPkg::row_t         rowOut,
    output logic                        rowValid
);

    localparam int NumElems = `MAT_DIM * `MAT_DIM;

    logic [NumElems*`ELEM_W-1:0] flatW;
    symmDecorrPkg::elem_t        w    [`MAT_DIM][`MAT_DIM];
    logic signed [`ACC_W-1:0]    wwT  [`MAT_DIM];
    logic signed [`ACC_W-1:0]    wwTw [`MAT_DIM];
    symmDecorrPkg::elem_t        prod [`MAT_DIM];

    assign flatW = matrixW;

    for (genvar r = 0; r < `MAT_DIM; r++) begin : genRow
        for (genvar c = 0; c < `MAT_DIM; c++) begin : genCol
            assign w[r][c] = flatW[(NumElems - 1 - (r * `MAT_DIM + c)) * `ELEM_W +: `ELEM_W];
        end
    end

    // Row ROW_IDX of W*W', then that row times W
    always_comb begin
        for (int j = 0; j < `MAT_DIM; j++) begin
            wwT[j] = '0;
            for (int k = 0; k < `MAT_DIM; k++) begin
                wwT[j] += (`ACC_W'(w[ROW_IDX][k]) * `ACC_W'(w[j][k])) >>> `FRAC_BITS;
            end
        end
        for (int c = 0; c < `MAT_DIM; c++) begin
            wwTw[c] = '0;
            for (int j = 0; j < `MAT_DIM; j++) begin
                wwTw[c] += (wwT[j] * `ACC_W'(w[j][c])) >>> `FRAC_BITS;
            end
            prod[c] = symmDecorrPkg::elem_t'(wwTw[c] >>> 1);  // Halved, truncated
        end
    end

    always_ff @(posedge clk_mul3) begin
        if (rst) begin
            rowValid <= 1'b0;
        end else begin
            rowValid <= matReady;
        end
    end

    always_ff @(posedge clk_mul3) begin
        if (matReady) begin
            if (mulEn) begin
                rowOut <= '{c0: prod[0], c1: prod[1], c2: prod[2], c3: prod[3]};
            end else begin
                rowOut <= '{c0: w[ROW_IDX][0], c1: w[ROW_IDX][1],
                            c2: w[ROW_IDX][2], c3: w[ROW_IDX][3]};  // Bypass
            end
        end
    end

endmodule

`default_nettype wire

// File: decorrUpdate.sv
`default_nettype none

`include "symmDecorr_params.svh"

module decorrUpdate (
    input  wire logic                   clk_mul3,
    input  wire logic                   rst,
    input  wire logic                   rowValid,
    input  wire symmDecorrPkg::matrix_t prodRows,
    input  wire symmDecorrPkg::matrix_t matrixW,
    output logic                        outValid,
    output symmDecorrPkg::elem_t        outData,
    output logic                        busy
);

    localparam int NumElems = `MAT_DIM * `MAT_DIM;
    localparam int FlatW    = NumElems * `ELEM_W;

    logic [FlatW-1:0] flatW;
    logic [FlatW-1:0] flatP;
    logic [FlatW-1:0] updFlat;
    logic [FlatW-1:0] outShift;
    logic [3:0]       outCnt;

    assign flatW = matrixW;
    assign flatP = prodRows;

    // Both operands share the flat layout, so no reordering is needed
    for (genvar i = 0; i < NumElems; i++) begin : genUpd
        symmDecorrPkg::elem_t      wElem;
        symmDecorrPkg::elem_t      pElem;
        logic signed [`ELEM_W+1:0] sum;

        assign wElem = flatW[i*`ELEM_W +: `ELEM_W];
        assign pElem = flatP[i*`ELEM_W +: `ELEM_W];
        assign sum   = wElem + (wElem >>> 1) - pElem;  // 1.5*W - P
        assign updFlat[i*`ELEM_W +: `ELEM_W] = sum[`ELEM_W-1:0];
    end

    always_ff @(posedge clk_mul3) begin
        if (rst) begin
            outValid <= 1'b0;
            outCnt   <= '0;
        end else if (rowValid) begin
            outValid <= 1'b1;
            outCnt   <= '0;
        end else if (outValid) begin
            outCnt <= outCnt + 4'd1;
            if (outCnt == 4'(NumElems - 1)) begin
                outValid <= 1'b0;  // Last of 16
            end
        end
    end

    // Element 0 leaves first from the top slice
    always_ff @(posedge clk_mul3) begin
        if (rowValid) begin
            outShift <= updFlat;
        end else if (outValid) begin
            outShift <= outShift << `ELEM_W;
        end
    end

    assign outData = symmDecorrPkg::elem_t'(outShift[FlatW-1 -: `ELEM_W]);
    assign busy    = outValid;

endmodule

`default_nettype wire

// File: symmDecorrTop.sv
`default_nettype none

`include "symmDecorr_params.svh"

module symmDecorrTop (
    input  wire logic                 clk_mul3,
    input  wire logic                 rst,
    input  wire logic                 elemValid,
    input  wire symmDecorrPkg::elem_t elemData,
    input  wire logic                 mulEn,
    output logic                      outValid,
    output symmDecorrPkg::elem_t      outData,
    output logic                      busy
);

    symmDecorrPkg::matrix_t matrixW;
    symmDecorrPkg::matrix_t prodRows;
    symmDecorrPkg::row_t    rowRes [`MAT_DIM];
    logic [`MAT_DIM-1:0]    rowValid;
    logic                   matReady;

    matrixLoader i_matrixLoader (
        .clk_mul3 (clk_mul3),
        .rst      (rst),
        .elemValid(elemValid),
        .elemData (elemData),
        .matrixW  (matrixW),
        .matReady (matReady)
    );

    for (genvar r = 0; r < `MAT_DIM; r++) begin : genRowUnit
        symmMulRow #(
            .ROW_IDX(r)
        ) i_symmMulRow (
            .clk_mul3(clk_mul3),
            .rst     (rst),
            .matReady(matReady),
            .mulEn   (mulEn),
            .matrixW (matrixW),
            .rowOut  (rowRes[r]),
            .rowValid(rowValid[r])
        );
    end

    assign prodRows = '{r0: rowRes[0], r1: rowRes[1], r2: rowRes[2], r3: rowRes[3]};

    // All row units run in lockstep, row 0 stands for the set
    decorrUpdate i_decorrUpdate (
        .clk_mul3(clk_mul3),
        .rst     (rst),
        .rowValid(rowValid[0]),
        .prodRows(prodRows),
        .matrixW (matrixW),
        .outValid(outValid),
        .outData (outData),
        .busy    (busy)
    );

endmodule

`default_nettype wire

// File: symmDecorr_assert.sv
`default_nettype none

module symmDecorrAssert (
    input wire logic clk_mul3,
    input wire logic rst,
    input wire logic matReady,
    input wire logic outValid,
    input wire logic busy
);
    timeunit 1ns;
    timeprecision 100ps;

    // Outputs stay low through reset and on the cycle after it
    quietInReset: assert property (@(posedge clk_mul3) rst |=> (!outValid && !busy))
        else $error("outValid or busy high during or right after reset");

    singleReady: assert property (@(posedge clk_mul3) disable iff (rst)
        matReady |=> !matReady)
        else $error("matReady held longer than one cycle");

    // Back-to-back streams may join into one long run of outValid
    streamStart: assert property (@(posedge clk_mul3) disable iff (rst)
        matReady |-> ##2 outValid[*16])
        else $error("stream did not start 2 cycles after matReady or was shorter than 16");

    noEarlyRise: assert property (@(posedge clk_mul3) disable iff (rst)
        $rose(outValid) |-> $past(matReady, 2))
        else $error("outValid rose without matReady 2 cycles before");

    exactLength: assert property (@(posedge clk_mul3) disable iff (rst)
        $fell(outValid) |-> $past(matReady, 18))
        else $error("outValid run did not end 16 cycles after its last start");

    busyFollows: assert property (@(posedge clk_mul3) disable iff (rst)
        busy == outValid)
        else $error("busy differs from outValid");

endmodule

bind symmDecorrTop symmDecorrAssert i_symmDecorrAssert (
    .clk_mul3(clk_mul3),
    .rst     (rst),
    .matReady(matReady),
    .outValid(outValid),
    .busy    (busy)
);

`default_nettype wire

// File: symmDecorr_tb.sv
`default_nettype none

`include "symmDecorr_params.svh"

module symmDecorr_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int     NumMatrices     = 12;
    localparam int     CyclesPerMatrix = 40;
    localparam int     TimeoutCycles   = NumMatrices * CyclesPerMatrix + 200;
    localparam int     NumElems        = `MAT_DIM * `MAT_DIM;
    localparam longint One             = longint'(1) << `FRAC_BITS;

    logic                 clk_mul3;
    logic                 rst;
    logic                 elemValid;
    symmDecorrPkg::elem_t elemData;
    logic                 mulEn;
    logic                 outValid;
    symmDecorrPkg::elem_t outData;
    logic                 busy;

    logic [31:0]          lcgState;
    longint               curW [`MAT_DIM][`MAT_DIM];
    symmDecorrPkg::elem_t expQ [$];
    int                   cycleCnt = 0;

    symmDecorrTop i_symmDecorrTop (
        .clk_mul3 (clk_mul3),
        .rst      (rst),
        .elemValid(elemValid),
        .elemData (elemData),
        .mulEn    (mulEn),
        .outValid (outValid),
        .outData  (outData),
        .busy     (busy)
    );

    initial clk_mul3 = 1'b0;
    always #5 clk_mul3 = ~clk_mul3;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Two's complement wrap to the accumulator width
    function automatic longint wrapAcc(input longint x);
        logic signed [`ACC_W-1:0] t;
        t = x[`ACC_W-1:0];
        return t;
    endfunction

    function automatic symmDecorrPkg::elem_t toElem(input longint x);
        return symmDecorrPkg::elem_t'(x);
    endfunction

    task automatic abortRun();
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at the first error");
    endtask

    // Expected 1.5*W - (W*W'*W)/2 for curW or W>>>1 in bypass
    task automatic pushExpected(input bit en);
        longint wwT [`MAT_DIM][`MAT_DIM];
        longint acc;
        longint p;
        for (int i = 0; i < `MAT_DIM; i++) begin
            for (int j = 0; j < `MAT_DIM; j++) begin
                acc = 0;
                for (int k = 0; k < `MAT_DIM; k++) begin
                    acc = wrapAcc(acc + (wrapAcc(curW[i][k] * curW[j][k]) >>> `FRAC_BITS));
                end
                wwT[i][j] = acc;
            end
        end
        for (int i = 0; i < `MAT_DIM; i++) begin
            for (int c = 0; c < `MAT_DIM; c++) begin
                acc = 0;
                for (int j = 0; j < `MAT_DIM; j++) begin
                    acc = wrapAcc(acc + (wrapAcc(wwT[i][j] * curW[j][c]) >>> `FRAC_BITS));
                end
                p = en ? longint'(toElem(acc >>> 1)) : curW[i][c];
                expQ.push_back(toElem(curW[i][c] + (curW[i][c] >>> 1) - p));
            end
        end
    endtask

    task automatic fillIdentity();
        for (int r = 0; r < `MAT_DIM; r++) begin
            for (int c = 0; c < `MAT_DIM; c++) begin
                curW[r][c] = (r == c) ? One : 0;
            end
        end
    endtask

    task automatic fillRandom();
        for (int r = 0; r < `MAT_DIM; r++) begin
            for (int c = 0; c < `MAT_DIM; c++) begin
                curW[r][c] = longint'((nextRand() >> 16) % 16385) - One;  // -1.0 to +1.0
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_mul3);
            elemValid <= 1'b0;
            elemData  <= '0;
        end
    endtask

    task automatic sendMatrix(input bit en, input bit useGaps);
        int gap;
        for (int i = 0; i < NumElems; i++) begin
            @(posedge clk_mul3);
            elemValid <= 1'b1;
            elemData  <= toElem(curW[i / `MAT_DIM][i % `MAT_DIM]);
            if (i == NumElems - 1) begin
                mulEn <= en;  // Stable until the next matrix completes
                pushExpected(en);
            end else if (useGaps) begin
                gap = int'(nextRand() >> 31);
                repeat (gap) begin
                    @(posedge clk_mul3);
                    elemValid <= 1'b0;
                end
            end
        end
    endtask

    always @(posedge clk_mul3) begin : checkOutput
        symmDecorrPkg::elem_t expVal;
        if (!rst && outValid) begin
            noStrayOutput: assert (expQ.size() > 0) else begin
                $display("Output seen while no matrix result was pending");
                abortRun();
            end
            expVal = expQ.pop_front();
            dataMatch: assert (outData === expVal) else begin
                $display("Mismatch outData: expected %h, got %h", expVal, outData);
                abortRun();
            end
        end
    end

    always @(posedge clk_mul3) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= TimeoutCycles) begin
            $display("Timeout: test sequence not finished after %0d cycles", cycleCnt);
            abortRun();
        end
    end

    initial begin
        lcgState  = 32'h0d2567f5;
        rst       = 1'b1;
        elemValid = 1'b0;
        elemData  = '0;
        mulEn     = 1'b0;
        repeat (3) @(posedge clk_mul3);
        rst <= 1'b0;
        idle(8);  // Nothing may come out yet

        fillIdentity();
        sendMatrix(1'b1, 1'b0);
        idle(4);

        repeat (3) begin
            fillRandom();
            sendMatrix(1'b1, 1'b1);
        end
        idle(3);

        repeat (2) begin
            fillRandom();
            sendMatrix(1'b0, 1'b1);
        end
        idle(3);

        // Full strobe rate with the mode toggling per matrix
        fillRandom();
        sendMatrix(1'b1, 1'b0);
        fillRandom();
        sendMatrix(1'b0, 1'b0);
        fillRandom();
        sendMatrix(1'b1, 1'b0);
        idle(3);

        repeat (3) begin
            fillRandom();
            sendMatrix(1'b1, 1'b1);
        end
        idle(2);

        while (expQ.size() != 0) begin
            @(posedge clk_mul3);
        end
        repeat (4) @(posedge clk_mul3);  // Room for a stray output to show

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: symmDecorr.f
+incdir+.
symmDecorrPkg.sv
matrixLoader.sv
symmMulRow.sv
decorrUpdate.sv
symmDecorrTop.sv
symmDecorr_assert.sv
symmDecorr_tb.sv
